//--- logic/rtos_cfg_pkg.sv
/* task core widths, id and priority types,
   task state and command kinds */

package rtos_cfg_pkg;

    // largest task count the id width can hold
    localparam int TMAX_TASK_NUM = 15;

    typedef logic [3:0] tskid_t;
    typedef logic [3:0] tskpri_t;
    typedef logic [0:0] wupcnt_t;

    localparam wupcnt_t TMAX_WUPCNT = 1'b1;

    // id 0 is reserved for "no task"
    typedef enum logic [3:0] {
        TTS_RDY = 4'd2,
        TTS_WAI = 4'd4
    } tskstat_e;

    typedef enum logic [1:0] {
        CMD_WUP,
        CMD_SLP,
        CMD_CHG_PRI
    } task_cmd_e;

endpackage

//--- logic/rtos_map_pkg.sv
/* bus address map of the scheduler front end:
   opcodes, object ids and constant read values */

package rtos_map_pkg;

    typedef logic [15:0] wb_adr_t;
    typedef logic [31:0] wb_dat_t;
    typedef logic [7:0]  opcode_t;
    typedef logic [7:0]  objid_t;

    // ----------------------------------------
    // opcodes (upper address byte)
    // ----------------------------------------
    localparam opcode_t OPC_SYS_CFG     = 8'h00;
    localparam opcode_t OPC_CPU_CTL     = 8'h01;
    localparam opcode_t OPC_WUP_TSK     = 8'h10;
    localparam opcode_t OPC_SLP_TSK     = 8'h11;
    localparam opcode_t OPC_CHG_PRI     = 8'h1c;
    localparam opcode_t OPC_REF_TSKSTAT = 8'h90;
    localparam opcode_t OPC_REF_WUPCNT  = 8'h92;
    localparam opcode_t OPC_GET_PRI     = 8'h9c;

    // ----------------------------------------
    // object ids (lower address byte)
    // ----------------------------------------
    // system configuration block
    localparam objid_t SYS_CORE_ID    = 8'h00;
    localparam objid_t SYS_TMAX_TSKID = 8'h20;

    // cpu control block
    localparam objid_t CTL_TOP_TSKID  = 8'h00;
    localparam objid_t CTL_RUN_TSKID  = 8'h04;
    localparam objid_t CTL_RUN_TSKPRI = 8'h05;
    localparam objid_t CTL_COPY_TSKID = 8'h08;
    localparam objid_t CTL_IRQ_EN     = 8'h10;
    localparam objid_t CTL_IRQ_STS    = 8'h11;
    localparam objid_t CTL_IRQ_FORCE  = 8'h1f;

    // "RTOS" signature with the top bit set
    localparam wb_dat_t CORE_ID_VALUE = 32'h834f5452;

endpackage

//--- logic/task_if.sv
/* task command channel and per-task state view */

// ----------------------------------------
// one service call per cycle
// ----------------------------------------
interface task_cmd_if import rtos_cfg_pkg::*; ();

    logic      valid;
    task_cmd_e kind;
    tskid_t    tskid;
    tskpri_t   tskpri;

    modport decoder (output valid, kind, tskid, tskpri);
    modport tbl     (input  valid, kind, tskid, tskpri);

endinterface

// ----------------------------------------
// task table contents, indexed by task id
// ----------------------------------------
interface task_view_if import rtos_cfg_pkg::*; ();

    tskstat_e stat   [1:TMAX_TASK_NUM];
    tskpri_t  pri    [1:TMAX_TASK_NUM];
    wupcnt_t  wupcnt [1:TMAX_TASK_NUM];

    // one cycle after a command was applied
    logic     changed;

    modport tbl    (output stat, pri, wupcnt, changed);
    modport queue  (input  stat, pri, changed);
    modport reader (input  stat, pri, wupcnt);

endinterface

//--- logic/wb_decoder.sv
/* wishbone slave: acknowledge, address decode,
   task command issue and read data mux */

module wb_decoder
    import rtos_cfg_pkg::*;
    import rtos_map_pkg::*;
#(
    parameter int TASK_NUM = 7
) (
    input  logic               clk,
    input  logic               reset_i,

    input  wb_adr_t            wb_adr_i,
    input  wb_dat_t            wb_dat_i,
    input  logic               wb_we_i,
    input  logic               wb_stb_i,
    output wb_dat_t            wb_dat_o,
    output logic               wb_ack_o,

    input  logic               busy_i,
    input  tskid_t             top_tskid_i,

    task_cmd_if.decoder        cmd,
    task_view_if.reader        view,

    output logic               ctl_wr_o,
    output logic               ctl_rd_o,
    output objid_t             ctl_id_o,
    output wb_dat_t            ctl_wdata_o,
    input  wb_dat_t            ctl_rdata_i
);

    opcode_t opcode;
    objid_t  objid;
    tskid_t  task_idx;
    logic    id_ok;
    logic    bus_wr;
    logic    bus_rd;

    assign opcode   = wb_adr_i[15:8];
    assign objid    = wb_adr_i[7:0];
    assign task_idx = tskid_t'(objid);
    assign id_ok    = (objid != '0) && (objid <= objid_t'(TASK_NUM));

    // stall while the ready queue catches up
    assign wb_ack_o = wb_stb_i && !busy_i;
    assign bus_wr   = wb_ack_o && wb_we_i;
    assign bus_rd   = wb_ack_o && !wb_we_i;

    // ----------------------------------------
    // task service calls
    // ----------------------------------------
    assign cmd.tskid  = task_idx;
    assign cmd.tskpri = tskpri_t'(wb_dat_i);

    always_comb begin
        cmd.valid = 1'b0;
        cmd.kind  = CMD_WUP;
        if (bus_wr && id_ok) begin
            case (opcode)
                OPC_WUP_TSK: begin
                    cmd.valid = 1'b1;
                    cmd.kind  = CMD_WUP;
                end
                OPC_SLP_TSK: begin
                    cmd.valid = 1'b1;
                    cmd.kind  = CMD_SLP;
                end
                OPC_CHG_PRI: begin
                    cmd.valid = 1'b1;
                    cmd.kind  = CMD_CHG_PRI;
                end
                default: ;
            endcase
        end
    end

    // cpu control block
    assign ctl_wr_o    = bus_wr && (opcode == OPC_CPU_CTL);
    assign ctl_rd_o    = bus_rd && (opcode == OPC_CPU_CTL);
    assign ctl_id_o    = objid;
    assign ctl_wdata_o = wb_dat_i;

    // ----------------------------------------
    // read data
    // ----------------------------------------
    always_comb begin
        wb_dat_o = '0;
        case (opcode)
            OPC_SYS_CFG: begin
                if (objid == SYS_CORE_ID) begin
                    wb_dat_o = CORE_ID_VALUE;
                end else if (objid == SYS_TMAX_TSKID) begin
                    wb_dat_o = wb_dat_t'(TASK_NUM);
                end
            end
            OPC_CPU_CTL:     wb_dat_o = ctl_rdata_i;
            OPC_REF_TSKSTAT: wb_dat_o = id_ok ? wb_dat_t'(view.stat[task_idx]) : '0;
            OPC_REF_WUPCNT:  wb_dat_o = id_ok ? wb_dat_t'(view.wupcnt[task_idx]) : '0;
            OPC_GET_PRI:     wb_dat_o = id_ok ? wb_dat_t'(view.pri[task_idx]) : '0;
            default: ;
        endcase
    end

    // a command raises busy next cycle, and the ack is held off
    a_cmd_stalls_bus: assert property (@(posedge clk) disable iff (reset_i)
        cmd.valid |=> busy_i && !wb_ack_o)
        else $error("transfer acknowledged right after a task command");

    // once the queue is settled its top must be a ready task
    a_top_is_ready: assert property (@(posedge clk) disable iff (reset_i)
        (!busy_i && top_tskid_i != '0) |-> view.stat[top_tskid_i] == TTS_RDY)
        else $error("top task %0d is not ready", top_tskid_i);

endmodule

//--- logic/task_table.sv
/* per-task state, priority and wake-up count,
   updated by wup / slp / chg_pri commands */

module task_table
    import rtos_cfg_pkg::*;
#(
    parameter int TASK_NUM = 7
) (
    input  logic        clk,
    input  logic        reset_i,

    task_cmd_if.tbl     cmd,
    task_view_if.tbl    view
);

    tskid_t   id;
    tskstat_e cur_stat;
    wupcnt_t  cur_cnt;

    assign id       = cmd.tskid;
    assign cur_stat = view.stat[id];
    assign cur_cnt  = view.wupcnt[id];

    // ----------------------------------------
    // task state update
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            // every task starts asleep, priority = id
            for (int i = 1; i <= TMAX_TASK_NUM; i++) begin
                view.stat[i]   <= TTS_WAI;
                view.pri[i]    <= tskpri_t'(i);
                view.wupcnt[i] <= '0;
            end
            view.changed <= 1'b0;
        end else begin
            view.changed <= cmd.valid;

            if (cmd.valid) begin
                case (cmd.kind)
                    CMD_WUP: begin
                        if (cur_stat == TTS_WAI) begin
                            view.stat[id] <= TTS_RDY;
                        end else if (cur_cnt != TMAX_WUPCNT) begin
                            // already ready, queue the wake-up
                            view.wupcnt[id] <= cur_cnt + 1'b1;
                        end
                    end
                    CMD_SLP: begin
                        if (cur_cnt != '0) begin
                            view.wupcnt[id] <= cur_cnt - 1'b1;
                        end else begin
                            view.stat[id] <= TTS_WAI;
                        end
                    end
                    CMD_CHG_PRI: begin
                        view.pri[id] <= cmd.tskpri;
                    end
                    default: ;
                endcase
            end
        end
    end

    // range check is done by the bus decoder
    a_cmd_id_range: assert property (@(posedge clk) disable iff (reset_i)
        cmd.valid |-> (cmd.tskid != '0) && (int'(cmd.tskid) <= TASK_NUM))
        else $error("task command with id %0d", cmd.tskid);

endmodule

//--- logic/ready_queue.sv
/* ready queue: registered pick of the most urgent
   ready task, and the busy window after updates */

module ready_queue
    import rtos_cfg_pkg::*;
#(
    parameter int TASK_NUM = 7
) (
    input  logic         clk,
    input  logic         reset_i,

    task_view_if.queue   view,

    output tskid_t       top_tskid_o,
    output tskpri_t      top_tskpri_o,
    output logic         busy_o
);

    tskid_t  best_id;
    tskpri_t best_pri;

    // strict compare, so the lower id keeps a tie
    always_comb begin
        best_id  = '0;
        best_pri = '1;
        for (int i = 1; i <= TASK_NUM; i++) begin
            if (view.stat[i] == TTS_RDY && (best_id == '0 || view.pri[i] < best_pri)) begin
                best_id  = tskid_t'(i);
                best_pri = view.pri[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            top_tskid_o  <= '0;
            top_tskpri_o <= '1;
        end else begin
            top_tskid_o  <= best_id;
            top_tskpri_o <= best_pri;
        end
    end

    // registered top lags the table by one cycle
    assign busy_o = view.changed;

endmodule

//--- logic/cpu_ctl.sv
/* cpu control: running task, copy-on-read,
   irq enable / force and dispatch interrupt */

module cpu_ctl
    import rtos_cfg_pkg::*;
    import rtos_map_pkg::*;
(
    input  logic     clk,
    input  logic     reset_i,

    input  logic     ctl_wr_i,
    input  logic     ctl_rd_i,
    input  objid_t   ctl_id_i,
    input  wb_dat_t  ctl_wdata_i,
    output wb_dat_t  ctl_rdata_o,

    input  tskid_t   top_tskid_i,
    input  tskpri_t  top_tskpri_i,
    input  logic     busy_i,

    output logic     irq_o
);

    tskid_t  run_tskid;
    tskpri_t run_tskpri;
    logic    irq_en;
    logic    irq_force;
    logic    reg_switch;
    logic    reg_irq;
    logic    mismatch;

    assign mismatch = (top_tskid_i != run_tskid);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            run_tskid  <= '0;
            run_tskpri <= '1;
            irq_en     <= 1'b0;
            irq_force  <= 1'b0;
            reg_switch <= 1'b0;
            reg_irq    <= 1'b0;
        end else begin
            if (ctl_wr_i) begin
                case (ctl_id_i)
                    CTL_RUN_TSKID:  run_tskid  <= tskid_t'(ctl_wdata_i);
                    CTL_RUN_TSKPRI: run_tskpri <= tskpri_t'(ctl_wdata_i);
                    CTL_IRQ_EN:     irq_en     <= ctl_wdata_i[0];
                    CTL_IRQ_FORCE:  irq_force  <= ctl_wdata_i[0];
                    default: ;
                endcase
            end

            // reading the top also makes it the running task
            if (ctl_rd_i && ctl_id_i == CTL_COPY_TSKID) begin
                run_tskid  <= top_tskid_i;
                run_tskpri <= top_tskpri_i;
            end

            // two settled mismatches in a row before interrupting
            if (!busy_i) begin
                reg_switch <= mismatch;
                reg_irq    <= mismatch && reg_switch;
            end
        end
    end

    assign irq_o = (reg_irq && irq_en) || irq_force;

    always_comb begin
        ctl_rdata_o = '0;
        case (ctl_id_i)
            CTL_TOP_TSKID:  ctl_rdata_o = wb_dat_t'(top_tskid_i);
            CTL_COPY_TSKID: ctl_rdata_o = wb_dat_t'(top_tskid_i);
            CTL_RUN_TSKID:  ctl_rdata_o = wb_dat_t'(run_tskid);
            CTL_RUN_TSKPRI: ctl_rdata_o = wb_dat_t'(run_tskpri);
            CTL_IRQ_EN:     ctl_rdata_o = wb_dat_t'(irq_en);
            CTL_IRQ_STS:    ctl_rdata_o = wb_dat_t'(irq_o);
            default: ;
        endcase
    end

    // the copied top must be a settled one
    a_copy_settled: assert property (@(posedge clk) disable iff (reset_i)
        (ctl_rd_i && ctl_id_i == CTL_COPY_TSKID) |-> !busy_i)
        else $error("running task copied while the ready queue is busy");

endmodule

//--- logic/rtos_top.sv
/* scheduler top: wishbone front end, task table,
   ready queue and cpu control */

module rtos_top
    import rtos_cfg_pkg::*;
    import rtos_map_pkg::*;
#(
    parameter int TASK_NUM = 7
) (
    input  logic     clk,
    input  logic     reset_i,

    input  wb_adr_t  s_wb_adr_i,
    input  wb_dat_t  s_wb_dat_i,
    input  logic     s_wb_we_i,
    input  logic     s_wb_stb_i,
    output wb_dat_t  s_wb_dat_o,
    output logic     s_wb_ack_o,

    output logic     irq_o
);

    tskid_t  top_tskid;
    tskpri_t top_tskpri;
    logic    busy;
    logic    ctl_wr;
    logic    ctl_rd;
    objid_t  ctl_id;
    wb_dat_t ctl_wdata;
    wb_dat_t ctl_rdata;

    task_cmd_if  cmd_if ();
    task_view_if view_if ();

    wb_decoder #(
        .TASK_NUM (TASK_NUM)
    ) u_decoder (
        .clk         (clk),
        .reset_i     (reset_i),
        .wb_adr_i    (s_wb_adr_i),
        .wb_dat_i    (s_wb_dat_i),
        .wb_we_i     (s_wb_we_i),
        .wb_stb_i    (s_wb_stb_i),
        .wb_dat_o    (s_wb_dat_o),
        .wb_ack_o    (s_wb_ack_o),
        .busy_i      (busy),
        .top_tskid_i (top_tskid),
        .cmd         (cmd_if.decoder),
        .view        (view_if.reader),
        .ctl_wr_o    (ctl_wr),
        .ctl_rd_o    (ctl_rd),
        .ctl_id_o    (ctl_id),
        .ctl_wdata_o (ctl_wdata),
        .ctl_rdata_i (ctl_rdata)
    );

    task_table #(
        .TASK_NUM (TASK_NUM)
    ) u_table (
        .clk     (clk),
        .reset_i (reset_i),
        .cmd     (cmd_if.tbl),
        .view    (view_if.tbl)
    );

    ready_queue #(
        .TASK_NUM (TASK_NUM)
    ) u_queue (
        .clk          (clk),
        .reset_i      (reset_i),
        .view         (view_if.queue),
        .top_tskid_o  (top_tskid),
        .top_tskpri_o (top_tskpri),
        .busy_o       (busy)
    );

    cpu_ctl u_cpu_ctl (
        .clk          (clk),
        .reset_i      (reset_i),
        .ctl_wr_i     (ctl_wr),
        .ctl_rd_i     (ctl_rd),
        .ctl_id_i     (ctl_id),
        .ctl_wdata_i  (ctl_wdata),
        .ctl_rdata_o  (ctl_rdata),
        .top_tskid_i  (top_tskid),
        .top_tskpri_i (top_tskpri),
        .busy_i       (busy),
        .irq_o        (irq_o)
    );

endmodule

//--- verif/tb_rtos.sv
/* testbench for the scheduler front end: bus tasks, LCG,
   task model, test sequence and checking assertions */

module tb_rtos
    import rtos_cfg_pkg::*;
    import rtos_map_pkg::*;
();

    localparam int TASK_NUM      = 7;
    localparam int N_RANDOM      = 200;
    localparam int ST_RDY        = 2;
    localparam int ST_WAI        = 4;
    // bus transfers of tests 1..6, in order
    localparam int PLANNED_XFERS = 10 + 13 + 7 + 5 + 3 * N_RANDOM + 8 + 19;
    localparam int CYCLE_LIMIT   = 20 * PLANNED_XFERS;

    logic    clk;
    logic    reset_i;
    wb_adr_t s_wb_adr_i;
    wb_dat_t s_wb_dat_i;
    logic    s_wb_we_i;
    logic    s_wb_stb_i;
    wb_dat_t s_wb_dat_o;
    logic    s_wb_ack_o;
    logic    irq_o;

    logic        ack_seen;
    wb_dat_t     dat_seen;
    logic        chk_en;
    wb_dat_t     chk_got;
    wb_dat_t     chk_exp;
    string       chk_msg;
    logic        task_wr;
    int          error_cnt = 0;
    int          check_cnt = 0;
    int          test_cnt = 0;
    int          failed_cnt = 0;
    int          test_errs = 0;
    int          cycle_cnt = 0;
    logic [31:0] lcg_state = 32'd89;

    // reference task table
    int m_stat [1:TASK_NUM];
    int m_pri  [1:TASK_NUM];
    int m_cnt  [1:TASK_NUM];

    rtos_top #(
        .TASK_NUM (TASK_NUM)
    ) dut (
        .clk        (clk),
        .reset_i    (reset_i),
        .s_wb_adr_i (s_wb_adr_i),
        .s_wb_dat_i (s_wb_dat_i),
        .s_wb_we_i  (s_wb_we_i),
        .s_wb_stb_i (s_wb_stb_i),
        .s_wb_dat_o (s_wb_dat_o),
        .s_wb_ack_o (s_wb_ack_o),
        .irq_o      (irq_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // bus responses as seen at the rising edge
    always @(posedge clk) begin
        ack_seen <= s_wb_ack_o;
        dat_seen <= s_wb_dat_o;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test FAILED");
            $finish;
        end
    end

    assign task_wr = s_wb_ack_o && s_wb_we_i
        && (s_wb_adr_i[15:8] == OPC_WUP_TSK || s_wb_adr_i[15:8] == OPC_SLP_TSK
            || s_wb_adr_i[15:8] == OPC_CHG_PRI)
        && (s_wb_adr_i[7:0] >= 8'd1) && (s_wb_adr_i[7:0] <= 8'(TASK_NUM));

    // ----------------------------------------
    // checking assertions
    // ----------------------------------------
    a_value: assert property (@(posedge clk) chk_en |-> chk_got == chk_exp)
        else begin
            error_cnt++;
            $display("ERROR: %0t: %s read %0h, expected %0h", $time, chk_msg, chk_got, chk_exp);
        end

    a_no_ack_idle: assert property (@(posedge clk) !s_wb_stb_i |-> !s_wb_ack_o)
        else begin
            error_cnt++;
            $display("ERROR: %0t: acknowledge raised without a strobe", $time);
        end

    a_irq_after_reset: assert property (@(posedge clk) reset_i |=> !irq_o)
        else begin
            error_cnt++;
            $display("ERROR: %0t: irq_o high right after reset", $time);
        end

    a_stall_after_task_write: assert property (@(posedge clk) disable iff (reset_i)
        task_wr |=> !s_wb_ack_o)
        else begin
            error_cnt++;
            $display("ERROR: %0t: transfer acknowledged right after a task write", $time);
        end

    // ----------------------------------------
    // random numbers and task model
    // ----------------------------------------
    function automatic int next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[30:16]);
    endfunction

    function automatic void reset_model();
        for (int i = 1; i <= TASK_NUM; i++) begin
            m_stat[i] = ST_WAI;
            m_pri[i]  = i;
            m_cnt[i]  = 0;
        end
    endfunction

    function automatic void apply_cmd(opcode_t opc, int id, int pri);
        if (id < 1 || id > TASK_NUM) begin
            return;
        end
        case (opc)
            OPC_WUP_TSK: begin
                if (m_stat[id] == ST_WAI) begin
                    m_stat[id] = ST_RDY;
                end else if (m_cnt[id] < 1) begin
                    m_cnt[id]++;
                end
            end
            OPC_SLP_TSK: begin
                if (m_cnt[id] > 0) begin
                    m_cnt[id]--;
                end else begin
                    m_stat[id] = ST_WAI;
                end
            end
            OPC_CHG_PRI: m_pri[id] = pri;
            default: ;
        endcase
    endfunction

    // smallest priority wins, lower id on a tie
    function automatic int best_ready();
        int best = 0;
        int best_pri = 16;
        for (int i = 1; i <= TASK_NUM; i++) begin
            if (m_stat[i] == ST_RDY && m_pri[i] < best_pri) begin
                best     = i;
                best_pri = m_pri[i];
            end
        end
        return best;
    endfunction

    // ----------------------------------------
    // bus and check tasks, called on a falling edge
    // ----------------------------------------
    task automatic wait_ack();
        do begin
            @(negedge clk);
        end while (!ack_seen);
        s_wb_stb_i = 1'b0;
        s_wb_we_i  = 1'b0;
    endtask

    task automatic wb_write(input opcode_t opc, input objid_t id, input wb_dat_t data);
        s_wb_adr_i = {opc, id};
        s_wb_dat_i = data;
        s_wb_we_i  = 1'b1;
        s_wb_stb_i = 1'b1;
        wait_ack();
    endtask

    task automatic wb_read(input opcode_t opc, input objid_t id, output wb_dat_t data);
        s_wb_adr_i = {opc, id};
        s_wb_we_i  = 1'b0;
        s_wb_stb_i = 1'b1;
        wait_ack();
        data = dat_seen;
    endtask

    task automatic check_value(input wb_dat_t got, input wb_dat_t exp, input string msg);
        chk_got = got;
        chk_exp = exp;
        chk_msg = msg;
        chk_en  = 1'b1;
        check_cnt++;
        @(negedge clk);
        chk_en = 1'b0;
    endtask

    task automatic read_expect(input opcode_t opc, input objid_t id, input wb_dat_t exp,
                               input string msg);
        wb_dat_t data;
        wb_read(opc, id, data);
        check_value(data, exp, msg);
    endtask

    task automatic issue_cmd(input opcode_t opc, input int id, input int pri);
        wb_write(opc, objid_t'(id), wb_dat_t'(pri));
        apply_cmd(opc, id, pri);
    endtask

    task automatic check_top();
        read_expect(OPC_CPU_CTL, CTL_TOP_TSKID, wb_dat_t'(best_ready()), "top task id");
    endtask

    task automatic check_states();
        for (int i = 1; i <= TASK_NUM; i++) begin
            read_expect(OPC_REF_TSKSTAT, objid_t'(i), wb_dat_t'(m_stat[i]),
                        $sformatf("state of task %0d", i));
        end
    endtask

    task automatic report_test(input string name);
        test_cnt++;
        if (error_cnt == test_errs) begin
            $display("test %0d %s: pass", test_cnt, name);
        end else begin
            failed_cnt++;
            $display("test %0d %s: FAIL (%0d errors)", test_cnt, name, error_cnt - test_errs);
        end
        test_errs = error_cnt;
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------
    task automatic check_reset_config();
        check_value(wb_dat_t'(irq_o), 32'd0, "irq_o after reset");
        read_expect(OPC_SYS_CFG, SYS_CORE_ID, 32'h834f5452, "core id");
        read_expect(OPC_SYS_CFG, SYS_TMAX_TSKID, wb_dat_t'(TASK_NUM), "task count");
        check_top();
        check_states();
    endtask

    task automatic wakeup_order();
        issue_cmd(OPC_WUP_TSK, 5, 0);
        check_top();
        issue_cmd(OPC_WUP_TSK, 3, 0);
        check_top();
        issue_cmd(OPC_WUP_TSK, 6, 0);
        check_top();
        check_states();
    endtask

    task automatic queued_wakeup();
        issue_cmd(OPC_WUP_TSK, 5, 0);
        read_expect(OPC_REF_WUPCNT, 8'd5, 32'd1, "count after second wup");
        issue_cmd(OPC_SLP_TSK, 5, 0);
        read_expect(OPC_REF_TSKSTAT, 8'd5, 32'd2, "state after first slp");
        read_expect(OPC_REF_WUPCNT, 8'd5, 32'd0, "count after first slp");
        issue_cmd(OPC_SLP_TSK, 5, 0);
        read_expect(OPC_REF_TSKSTAT, 8'd5, 32'd4, "state after second slp");
    endtask

    task automatic priority_changes();
        opcode_t opc;
        int      id;
        int      pri;
        int      sel;
        // equal priority with task 3, so task 3 stays on top
        issue_cmd(OPC_CHG_PRI, 6, 3);
        read_expect(OPC_GET_PRI, 8'd6, 32'd3, "priority of task 6");
        check_top();
        issue_cmd(OPC_CHG_PRI, 6, 1);
        check_top();
        for (int n = 0; n < N_RANDOM; n++) begin
            case (next_rand() % 3)
                0: opc = OPC_WUP_TSK;
                1: opc = OPC_SLP_TSK;
                default: opc = OPC_CHG_PRI;
            endcase
            id  = 1 + next_rand() % TASK_NUM;
            pri = next_rand() % 16;
            issue_cmd(opc, id, pri);
            check_top();
            sel = next_rand() % 3;
            if (sel == 0) begin
                read_expect(OPC_REF_TSKSTAT, objid_t'(id), wb_dat_t'(m_stat[id]),
                            $sformatf("state of task %0d", id));
            end else if (sel == 1) begin
                read_expect(OPC_REF_WUPCNT, objid_t'(id), wb_dat_t'(m_cnt[id]),
                            $sformatf("count of task %0d", id));
            end else begin
                read_expect(OPC_GET_PRI, objid_t'(id), wb_dat_t'(m_pri[id]),
                            $sformatf("priority of task %0d", id));
            end
        end
    endtask

    task automatic dispatch_irq();
        logic seen;
        seen = 1'b0;
        // a ready task guarantees top differs from the idle run id
        issue_cmd(OPC_WUP_TSK, 2, 0);
        wb_write(OPC_CPU_CTL, CTL_IRQ_EN, 32'd1);
        repeat (4) begin
            @(negedge clk);
            if (irq_o) begin
                seen = 1'b1;
            end
        end
        check_value(wb_dat_t'(seen), 32'd1, "irq_o with a pending switch");
        read_expect(OPC_CPU_CTL, CTL_COPY_TSKID, wb_dat_t'(best_ready()), "copied task id");
        read_expect(OPC_CPU_CTL, CTL_RUN_TSKID, wb_dat_t'(best_ready()), "running task id");
        check_value(wb_dat_t'(irq_o), 32'd0, "irq_o after dispatch");
        wb_write(OPC_CPU_CTL, CTL_IRQ_FORCE, 32'd1);
        read_expect(OPC_CPU_CTL, CTL_IRQ_STS, 32'd1, "forced irq status");
        wb_write(OPC_CPU_CTL, CTL_IRQ_FORCE, 32'd0);
        read_expect(OPC_CPU_CTL, CTL_IRQ_STS, 32'd0, "irq status without force");
    endtask

    task automatic bad_ids();
        int id;
        for (int k = 0; k < 2; k++) begin
            id = (k == 0) ? 0 : TASK_NUM + 1;
            issue_cmd(OPC_WUP_TSK, id, 0);
            issue_cmd(OPC_SLP_TSK, id, 0);
            issue_cmd(OPC_CHG_PRI, id, 9);
            read_expect(OPC_REF_TSKSTAT, objid_t'(id), 32'd0, $sformatf("state at id %0d", id));
            read_expect(OPC_REF_WUPCNT, objid_t'(id), 32'd0, $sformatf("count at id %0d", id));
            read_expect(OPC_GET_PRI, objid_t'(id), 32'd0, $sformatf("priority at id %0d", id));
        end
        check_states();
    endtask

    initial begin
        s_wb_adr_i = '0;
        s_wb_dat_i = '0;
        s_wb_we_i  = 1'b0;
        s_wb_stb_i = 1'b0;
        chk_en     = 1'b0;
        chk_got    = '0;
        chk_exp    = '0;
        chk_msg    = "";
        reset_i    = 1'b1;
        reset_model();
        repeat (3) @(negedge clk);
        reset_i = 1'b0;

        check_reset_config();
        report_test("reset and configuration");
        wakeup_order();
        report_test("wake-up and ready queue");
        queued_wakeup();
        report_test("queued wake-up");
        priority_changes();
        report_test("priority and random commands");
        dispatch_irq();
        report_test("dispatch interrupt");
        bad_ids();
        report_test("out-of-range ids");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_cnt, failed_cnt, check_cnt, error_cnt);
        if (error_cnt == 0 && failed_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
logic/rtos_cfg_pkg.sv
logic/rtos_map_pkg.sv
logic/task_if.sv
logic/wb_decoder.sv
logic/task_table.sv
logic/ready_queue.sv
logic/cpu_ctl.sv
logic/rtos_top.sv
verif/tb_rtos.sv

//--- Makefile
TOP := tb_rtos

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --top-module $(TOP) -f files.f -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
